// ==== src/upsample_pkg.sv ====
// bicubic upsampler shared types, weight sets and phase encoding
`default_nettype none

package upsample_pkg;

    localparam int PIX_W      = 8;
    localparam int COEF_W     = 12;
    localparam int ACC_W      = 32;
    localparam int FRAC_SHIFT = 22;
    localparam int PIX_MAX    = (1 << PIX_W) - 1;

    // vertical phase, listed in stepping order
    typedef enum logic [1:0] {
        PH_5_8 = 2'd0,
        PH_7_8 = 2'd1,
        PH_1_8 = 2'd2,
        PH_3_8 = 2'd3
    } phase_t;

    typedef logic [PIX_W-1:0]         pixel_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // index 0 is the top (or left) tap
    typedef coef_t  [3:0]      coef_set_t;
    typedef coef_set_t [3:0]   coef_bank_t;

    // window[row][col], row 0 on top, col 0 on the left
    typedef pixel_t [3:0][3:0] window_t;
    typedef acc_t   [3:0]      col_sums_t;
    typedef pixel_t [3:0]      pixel_quad_t;

    // weights with 11 fraction bits, each set sums to 2048
    localparam coef_set_t W_5_8 = {coef_t'(-225), coef_t'(1535), coef_t'(873), coef_t'(-135)};
    localparam coef_set_t W_7_8 = {coef_t'(-147), coef_t'(1981), coef_t'(235), coef_t'(-21)};
    localparam coef_set_t W_1_8 = {coef_t'(-21), coef_t'(235), coef_t'(1981), coef_t'(-147)};
    localparam coef_set_t W_3_8 = {coef_t'(-135), coef_t'(873), coef_t'(1535), coef_t'(-225)};

    // output pixel k uses entry k
    localparam coef_bank_t H_WEIGHTS = {W_7_8, W_5_8, W_3_8, W_1_8};

    function automatic coef_set_t phase_weights(phase_t ph);
        case (ph)
            PH_7_8:  return W_7_8;
            PH_1_8:  return W_1_8;
            PH_3_8:  return W_3_8;
            default: return W_5_8;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/upsample_phase_ctrl.sv ====
// phase controller, counts accepted windows across a row and steps the vertical phase
`timescale 1ns/1ps
`default_nettype none

module upsample_phase_ctrl
    import upsample_pkg::*;
#(
    parameter int IMG_WIDTH = 960
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   accept,
    output phase_t phase
);

    localparam int CNT_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(IMG_WIDTH - 1);

    logic [CNT_W-1:0] col_cnt;
    logic             row_done;
    phase_t           phase_nxt;

    // last window of the current source row
    assign row_done = accept && (col_cnt == CNT_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
        end else if (row_done) begin
            col_cnt <= '0;
        end else if (accept) begin
            col_cnt <= col_cnt + 1'b1;
        end
    end

    always_comb begin
        case (phase)
            PH_5_8:  phase_nxt = PH_7_8;
            PH_7_8:  phase_nxt = PH_1_8;
            PH_1_8:  phase_nxt = PH_3_8;
            default: phase_nxt = PH_5_8;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_5_8;
        end else if (row_done) begin
            phase <= phase_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== src/bicubic_vert_interp.sv ====
// vertical bicubic pass, one weighted sum down each window column
`timescale 1ns/1ps
`default_nettype none

module bicubic_vert_interp
    import upsample_pkg::*;
(
    input  window_t   window,
    input  phase_t    phase,
    output col_sums_t sums
);

    coef_set_t weights;

    assign weights = phase_weights(phase);

    always_comb begin
        acc_t acc;
        acc_t pix_ext;
        acc_t coef_ext;

        for (int c = 0; c < 4; c++) begin
            acc = '0;
            // top tap pairs with row 0
            for (int r = 0; r < 4; r++) begin
                pix_ext  = acc_t'({{(ACC_W - PIX_W){1'b0}}, window[r][c]});
                coef_ext = acc_t'(weights[r]);
                acc      = acc + coef_ext * pix_ext;
            end
            sums[c] = acc;
        end
    end

endmodule

`default_nettype wire

// ==== src/bicubic_horiz_interp.sv ====
// horizontal bicubic pass with rescale, clamp and the output register stage
`timescale 1ns/1ps
`default_nettype none

module bicubic_horiz_interp
    import upsample_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        advance,
    input  logic        in_valid,
    input  col_sums_t   in_sums,
    input  phase_t      in_phase,
    output logic        out_valid,
    output pixel_quad_t out_pixels,
    output phase_t      out_phase
);

    acc_t        row_sums [4];
    pixel_quad_t quad;

    // four products per output pixel, column 0 on the first tap
    always_comb begin
        acc_t      acc;
        coef_set_t hw;

        for (int k = 0; k < 4; k++) begin
            hw  = H_WEIGHTS[k];
            acc = '0;
            for (int c = 0; c < 4; c++) begin
                acc = acc + in_sums[c] * acc_t'(hw[c]);
            end
            row_sums[k] = acc;
        end
    end

    // drop both fraction scales and saturate to the pixel range
    always_comb begin
        acc_t scaled;

        for (int k = 0; k < 4; k++) begin
            scaled = row_sums[k] >>> FRAC_SHIFT;
            if (scaled < 0) begin
                quad[k] = '0;
            end else if (scaled > acc_t'(PIX_MAX)) begin
                quad[k] = pixel_t'(PIX_MAX);
            end else begin
                quad[k] = scaled[PIX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_pixels <= quad;
            out_phase  <= in_phase;
        end
    end

endmodule

`default_nettype wire

// ==== src/bicubic_upsample.sv ====
// bicubic 4x upsampler top, window handshake and two-stage stallable pipeline
`timescale 1ns/1ps
`default_nettype none

module bicubic_upsample
    import upsample_pkg::*;
#(
    parameter int IMG_WIDTH = 960
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        req_valid,
    output logic        req_ready,
    input  window_t     req_window,

    output logic        rsp_valid,
    input  logic        rsp_ready,
    output pixel_quad_t rsp_pixels,
    output phase_t      rsp_phase
);

    logic      advance;
    logic      accept;
    phase_t    cur_phase;
    col_sums_t vert_sums;

    // stage 1 registers
    logic      s1_valid;
    col_sums_t s1_sums;
    phase_t    s1_phase;

    // pipeline moves whenever the output slot is empty or being drained
    assign advance   = ~rsp_valid | rsp_ready;
    assign req_ready = advance;
    assign accept    = req_valid & advance;

    upsample_phase_ctrl #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_phase_ctrl (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .phase  (cur_phase)
    );

    bicubic_vert_interp u_vert_interp (
        .window (req_window),
        .phase  (cur_phase),
        .sums   (vert_sums)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_sums  <= vert_sums;
            s1_phase <= cur_phase;
        end
    end

    // stage 2 sits inside the horizontal pass
    bicubic_horiz_interp u_horiz_interp (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .in_valid   (s1_valid),
        .in_sums    (s1_sums),
        .in_phase   (s1_phase),
        .out_valid  (rsp_valid),
        .out_pixels (rsp_pixels),
        .out_phase  (rsp_phase)
    );

endmodule

`default_nettype wire

// ==== bench/upsample_assert.sv ====
// handshake assertions bound into the upsampler top level
`timescale 1ns/1ps
`default_nettype none

module upsample_assert
    import upsample_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_ready,
    input  logic        rsp_valid,
    input  logic        rsp_ready,
    input  pixel_quad_t rsp_pixels,
    input  phase_t      rsp_phase
);

    // number of assertion failures so far
    int fail_count = 0;

    // synchronous reset clears the output slot
    a_reset_clears: assert property (@(posedge clk) rst |=> !rsp_valid)
        else begin
            $error("rsp_valid high after a reset edge");
            fail_count++;
        end

    // a stalled response holds its value
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_pixels) && $stable(rsp_phase))
        else begin
            $error("response changed while stalled");
            fail_count++;
        end

    a_ready_rule: assert property (@(posedge clk) disable iff (rst)
        req_ready == (!rsp_valid || rsp_ready))
        else begin
            $error("req_ready does not follow the advance rule");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== bench/tb_upsample.sv ====
// testbench for the bicubic upsampler, random windows and stalls checked against a model
`timescale 1ns/1ps
`default_nettype none

module tb_upsample
    import upsample_pkg::*;
;

    localparam int WIDTH      = 5;
    localparam int N_RANDOM   = 400;
    localparam int WAIT_LIMIT = 200;
    localparam int FRAC_BITS  = 22;

    // weight sets in phase order 5/8, 7/8, 1/8, 3/8, top tap first
    localparam int WSET [4][4] = '{
        '{-135, 873, 1535, -225},
        '{-21, 235, 1981, -147},
        '{-147, 1981, 235, -21},
        '{-225, 1535, 873, -135}
    };
    // output pixel k uses the 1/8, 3/8, 5/8, 7/8 sets
    localparam int HSET [4] = '{2, 3, 0, 1};

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    window_t     req_window;
    logic        rsp_valid;
    logic        rsp_ready;
    pixel_quad_t rsp_pixels;
    phase_t      rsp_phase;

    pixel_quad_t exp_pix [$];
    phase_t      exp_ph [$];
    int          accepted;
    int          responses;
    int          errors;
    int          cycle;
    int          accept_cycle;
    int          rsp_cycle;
    bit          bp_enable;

    bicubic_upsample #(
        .IMG_WIDTH (WIDTH)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_window (req_window),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_pixels (rsp_pixels),
        .rsp_phase  (rsp_phase)
    );

    bind bicubic_upsample upsample_assert u_assert (
        .clk        (clk),
        .rst        (rst),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_pixels (rsp_pixels),
        .rsp_phase  (rsp_phase)
    );

    always #10 clk = ~clk;

    function automatic phase_t phase_of(int idx);
        case (idx)
            1:       return PH_7_8;
            2:       return PH_1_8;
            3:       return PH_3_8;
            default: return PH_5_8;
        endcase
    endfunction

    // column pass, row pass, then shift and clamp
    function automatic pixel_quad_t model_quad(window_t w, int set_idx);
        int          col [4];
        int          acc;
        pixel_quad_t q;
        for (int c = 0; c < 4; c++) begin
            col[c] = 0;
            for (int r = 0; r < 4; r++) begin
                col[c] += WSET[set_idx][r] * int'(w[r][c]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            acc = 0;
            for (int c = 0; c < 4; c++) begin
                acc += col[c] * WSET[HSET[k]][c];
            end
            acc = acc >>> FRAC_BITS;
            if (acc < 0) begin
                q[k] = 8'd0;
            end else if (acc > 255) begin
                q[k] = 8'd255;
            end else begin
                q[k] = acc[7:0];
            end
        end
        return q;
    endfunction

    function automatic window_t random_window();
        window_t w;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                w[r][c] = 8'($urandom_range(0, 255));
            end
        end
        return w;
    endfunction

    function automatic window_t centre_window(logic [7:0] centre, logic [7:0] edge_val);
        window_t w;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                w[r][c] = (r inside {1, 2} && c inside {1, 2}) ? centre : edge_val;
            end
        end
        return w;
    endfunction

    task automatic check_pixels(input pixel_quad_t exp, input pixel_quad_t act);
        if (act !== exp) begin
            $display("MISMATCH t=%0t rsp_pixels expected %h actual %h", $time, exp, act);
            errors++;
        end
    endtask

    task automatic check_phase(input phase_t exp, input phase_t act);
        if (act !== exp) begin
            $display("MISMATCH t=%0t rsp_phase expected %s actual %s", $time,
                     exp.name(), act.name());
            errors++;
        end
    endtask

    // sample both handshakes before the edge, then drive after it
    task automatic step_cycle();
        @(negedge clk);
        if (req_valid && req_ready) begin
            exp_pix.push_back(model_quad(req_window, (accepted / WIDTH) % 4));
            exp_ph.push_back(phase_of((accepted / WIDTH) % 4));
            accepted++;
            accept_cycle = cycle;
        end
        if (rsp_valid && rsp_ready) begin
            if (exp_pix.size() == 0) begin
                $display("response at t=%0t arrived with no window outstanding", $time);
                errors++;
            end else begin
                check_pixels(exp_pix.pop_front(), rsp_pixels);
                check_phase(exp_ph.pop_front(), rsp_phase);
            end
            responses++;
            rsp_cycle = cycle;
        end
        @(posedge clk);
        #2;
        rsp_ready = bp_enable ? ($urandom_range(0, 99) >= 30) : 1'b1;
        cycle++;
    endtask

    task automatic send_window(input window_t w);
        int start;
        int waited;
        start = accepted;
        waited = 0;
        req_valid = 1'b1;
        req_window = w;
        while (accepted == start && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (accepted == start) begin
            $display("timeout: window was not accepted within %0d cycles", WAIT_LIMIT);
            errors++;
        end
        req_valid = 1'b0;
    endtask

    initial begin
        int start;
        int waited;
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_window = '0;
        rsp_ready = 1'b0;
        bp_enable = 1'b0;
        accepted = 0;
        responses = 0;
        errors = 0;
        cycle = 0;
        void'($urandom(32'h1ff8));
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        rsp_ready = 1'b1;
        if (rsp_valid !== 1'b0) begin
            $display("rsp_valid is not low after reset");
            errors++;
        end

        // isolated window, response expected on the second sample after acceptance
        start = responses;
        waited = 0;
        send_window(random_window());
        while (responses == start && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (responses == start) begin
            $display("timeout: no response to the first window");
            errors++;
        end else if (rsp_cycle - accept_cycle != 2) begin
            $display("MISMATCH t=%0t latency expected 2 actual %0d", $time,
                     rsp_cycle - accept_cycle);
            errors++;
        end

        // flat windows pass through, bright and dark centres hit the clamp
        send_window(centre_window(8'h5a, 8'h5a));
        send_window(centre_window(8'h00, 8'h00));
        send_window(centre_window(8'hff, 8'hff));
        send_window(centre_window(8'hff, 8'h00));
        send_window(centre_window(8'h00, 8'hff));
        send_window(centre_window(8'hff, 8'h10));

        bp_enable = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            if ($urandom_range(0, 99) < 40) begin
                repeat ($urandom_range(1, 3)) step_cycle();
            end
            send_window(random_window());
        end

        bp_enable = 1'b0;
        waited = 0;
        while (exp_pix.size() > 0 && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (exp_pix.size() > 0) begin
            $display("timeout: %0d responses still outstanding", exp_pix.size());
            errors++;
        end
        if (responses != accepted) begin
            $display("response count %0d differs from accepted count %0d", responses, accepted);
            errors++;
        end

        $display("accepted %0d responses %0d errors %0d assertion failures %0d",
                 accepted, responses, errors, DUT.u_assert.fail_count);
        if (errors == 0 && DUT.u_assert.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/upsample_pkg.sv
src/upsample_phase_ctrl.sv
src/bicubic_vert_interp.sv
src/bicubic_horiz_interp.sv
src/bicubic_upsample.sv
bench/upsample_assert.sv
bench/tb_upsample.sv
